/* source/core_v_mini_mcu_pkg.sv */
//********************************************************************
// Address map, register indices and interrupt bit positions
// Bus address union with RAM and peripheral views
//********************************************************************

package core_v_mini_mcu_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Upper 16 address bits
  localparam logic [15:0] RAM_REGION       = 16'h0000;
  localparam logic [15:0] AO_PERIPH_REGION = 16'h2000;

  localparam int NUM_BANKS  = 2;
  localparam int BANK_WORDS = 256;
  localparam int NUM_GPIO   = 8;

  // Peripheral blocks, code 3 unmapped
  localparam logic [1:0] AO_BLOCK    = 2'd0;
  localparam logic [1:0] TIMER_BLOCK = 2'd1;
  localparam logic [1:0] GPIO_BLOCK  = 2'd2;

  localparam logic [1:0] EXIT_VALUE_REG = 2'd0;
  localparam logic [1:0] EXIT_VALID_REG = 2'd1;
  localparam logic [1:0] MSIP_REG       = 2'd2;

  localparam logic [1:0] TIMER_CTRL_REG  = 2'd0;
  localparam logic [1:0] TIMER_COUNT_REG = 2'd1;
  localparam logic [1:0] TIMER_CMP_REG   = 2'd2;

  localparam logic [1:0] GPIO_OUT_REG  = 2'd0;
  localparam logic [1:0] GPIO_OE_REG   = 2'd1;
  localparam logic [1:0] GPIO_IN_REG   = 2'd2;
  localparam logic [1:0] GPIO_INTR_REG = 2'd3;

  // Interrupt vector layout
  localparam int IRQ_SOFTWARE  = 3;
  localparam int IRQ_TIMER     = 7;
  localparam int IRQ_EXTERNAL  = 11;
  localparam int IRQ_GPIO_BASE = 22;

  typedef struct packed {
    logic [15:0] region;
    logic [15:0] offset;
  } ram_addr_t;

  typedef struct packed {
    logic [15:0] region;
    logic [9:0]  rsvd;
    logic [1:0]  block;
    logic [1:0]  reg_idx;
    logic [1:0]  byte_off;
  } periph_addr_t;

  typedef union packed {
    ram_addr_t    ram;
    periph_addr_t periph;
  } bus_addr_u;

endpackage

/* source/obi_bus_if.sv */
//********************************************************************
// OBI request/grant/rvalid bus and peripheral register interface
//********************************************************************

`timescale 1ns/100ps

interface obi_bus_if
  import core_v_mini_mcu_pkg::*;
();
  logic                req;
  logic                gnt;
  logic [ADDR_W-1:0]   addr;
  logic                we;
  logic [DATA_W/8-1:0] be;
  logic [DATA_W-1:0]   wdata;
  logic                rvalid;
  logic [DATA_W-1:0]   rdata;

  // Grant comes from the bus, never from the target
  modport manager (output req, gnt, addr, we, be, wdata, input rvalid, rdata);
  modport subordinate (input req, gnt, addr, we, be, wdata, output rvalid, rdata);
endinterface

interface periph_reg_if
  import core_v_mini_mcu_pkg::*;
();
  logic              sel;
  logic              we;
  logic [1:0]        reg_idx;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;

  modport host (output sel, we, reg_idx, wdata, input rdata);
  modport device (input sel, we, reg_idx, wdata, output rdata);
endinterface

/* source/rv_timer.sv */
//********************************************************************
// Free-running compare timer with level interrupt
//********************************************************************

`timescale 1ns/100ps

module rv_timer
  import core_v_mini_mcu_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,
  periph_reg_if.device reg_if,
  output logic         intr_o
);

  logic              wr_en;
  logic              enable_q;
  logic [DATA_W-1:0] count_q;
  logic [DATA_W-1:0] cmp_q;

  assign wr_en = reg_if.sel & reg_if.we;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q <= 1'b0;
      count_q  <= '0;
      cmp_q    <= '0;
    end else begin
      if (wr_en && reg_if.reg_idx == TIMER_CTRL_REG) begin
        enable_q <= reg_if.wdata[0];
      end
      if (wr_en && reg_if.reg_idx == TIMER_CMP_REG) begin
        cmp_q <= reg_if.wdata;
      end
      // Software write wins over the increment
      if (wr_en && reg_if.reg_idx == TIMER_COUNT_REG) begin
        count_q <= reg_if.wdata;
      end else if (enable_q) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (reg_if.reg_idx)
      TIMER_CTRL_REG:  reg_if.rdata = DATA_W'(enable_q);
      TIMER_COUNT_REG: reg_if.rdata = count_q;
      TIMER_CMP_REG:   reg_if.rdata = cmp_q;
      default:         reg_if.rdata = '0;
    endcase
  end

  assign intr_o = enable_q & (count_q >= cmp_q);

endmodule

/* source/gpio.sv */
//********************************************************************
// Always-on GPIO with rising-edge interrupt status
//********************************************************************

`timescale 1ns/100ps

module gpio
  import core_v_mini_mcu_pkg::*;
(
  input  logic                clk_i,
  input  logic                arst_n_i,
  periph_reg_if.device        reg_if,
  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_oe_o,
  output logic [NUM_GPIO-1:0] intr_o
);

  logic                wr_en;
  logic [NUM_GPIO-1:0] out_q;
  logic [NUM_GPIO-1:0] oe_q;
  logic [NUM_GPIO-1:0] sync1_q;
  logic [NUM_GPIO-1:0] sync2_q;
  logic [NUM_GPIO-1:0] prev_q;
  logic [NUM_GPIO-1:0] intr_q;
  logic [NUM_GPIO-1:0] rise;

  assign wr_en = reg_if.sel & reg_if.we;
  assign rise  = sync2_q & ~prev_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q   <= '0;
      oe_q    <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      intr_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr_en && reg_if.reg_idx == GPIO_OUT_REG) begin
        out_q <= reg_if.wdata[NUM_GPIO-1:0];
      end
      if (wr_en && reg_if.reg_idx == GPIO_OE_REG) begin
        oe_q <= reg_if.wdata[NUM_GPIO-1:0];
      end
      // New edges take priority over the clear
      if (wr_en && reg_if.reg_idx == GPIO_INTR_REG) begin
        intr_q <= (intr_q & ~reg_if.wdata[NUM_GPIO-1:0]) | rise;
      end else begin
        intr_q <= intr_q | rise;
      end
    end
  end

  always_comb begin
    case (reg_if.reg_idx)
      GPIO_OUT_REG:  reg_if.rdata = DATA_W'(out_q);
      GPIO_OE_REG:   reg_if.rdata = DATA_W'(oe_q);
      GPIO_IN_REG:   reg_if.rdata = DATA_W'(sync2_q);
      default:       reg_if.rdata = DATA_W'(intr_q);
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign intr_o    = intr_q;

endmodule

/* source/ao_peripheral_subsystem.sv */
//********************************************************************
// Always-on peripherals: exit and MSIP registers, timer, GPIO
//********************************************************************

`timescale 1ns/100ps

module ao_peripheral_subsystem
  import core_v_mini_mcu_pkg::*;
(
  input  logic                clk_i,
  input  logic                arst_n_i,
  obi_bus_if.subordinate      bus_i,
  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_oe_o,
  output logic                exit_valid_o,
  output logic [DATA_W-1:0]   exit_value_o,
  output logic                irq_software_o,
  output logic                irq_timer_o,
  output logic [NUM_GPIO-1:0] irq_gpio_o
);

  bus_addr_u         addr;
  logic [1:0]        block;
  logic [1:0]        reg_idx;
  logic              access;
  logic              ao_wr;
  logic [DATA_W-1:0] exit_value_q;
  logic              exit_valid_q;
  logic              msip_q;
  logic [DATA_W-1:0] rdata_d;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;

  periph_reg_if timer_reg ();
  periph_reg_if gpio_reg ();

  assign addr    = bus_i.addr;
  assign block   = addr.periph.block;
  assign reg_idx = addr.periph.reg_idx;
  assign access  = bus_i.req & bus_i.gnt;
  assign ao_wr   = access & bus_i.we & (block == AO_BLOCK);

  assign timer_reg.sel     = access & (block == TIMER_BLOCK);
  assign timer_reg.we      = bus_i.we;
  assign timer_reg.reg_idx = reg_idx;
  assign timer_reg.wdata   = bus_i.wdata;

  assign gpio_reg.sel     = access & (block == GPIO_BLOCK);
  assign gpio_reg.we      = bus_i.we;
  assign gpio_reg.reg_idx = reg_idx;
  assign gpio_reg.wdata   = bus_i.wdata;

  rv_timer rv_timer_i (
    .clk_i,
    .arst_n_i,
    .reg_if(timer_reg.device),
    .intr_o(irq_timer_o)
  );

  gpio gpio_i_ao (
    .clk_i,
    .arst_n_i,
    .reg_if(gpio_reg.device),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .intr_o(irq_gpio_o)
  );

  // Full word writes, byte enables ignored
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      msip_q       <= 1'b0;
    end else if (ao_wr) begin
      case (reg_idx)
        EXIT_VALUE_REG: exit_value_q <= bus_i.wdata;
        EXIT_VALID_REG: exit_valid_q <= bus_i.wdata[0];
        MSIP_REG:       msip_q       <= bus_i.wdata[0];
        default:        ;
      endcase
    end
  end

  always_comb begin
    rdata_d = '0;
    case (block)
      AO_BLOCK: begin
        case (reg_idx)
          EXIT_VALUE_REG: rdata_d = exit_value_q;
          EXIT_VALID_REG: rdata_d = DATA_W'(exit_valid_q);
          MSIP_REG:       rdata_d = DATA_W'(msip_q);
          default:        rdata_d = '0;
        endcase
      end
      TIMER_BLOCK: rdata_d = timer_reg.rdata;
      GPIO_BLOCK:  rdata_d = gpio_reg.rdata;
      default:     rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus_i.rvalid   = rvalid_q;
  assign bus_i.rdata    = rdata_q;
  assign exit_value_o   = exit_value_q;
  assign exit_valid_o   = exit_valid_q;
  assign irq_software_o = msip_q;

endmodule

/* source/memory_subsystem.sv */
//********************************************************************
// Banked SRAM with byte-enable writes
//********************************************************************

`timescale 1ns/100ps

module memory_subsystem
  import core_v_mini_mcu_pkg::*;
#(
  parameter int NUM_BANKS  = 2,
  parameter int BANK_WORDS = 256
) (
  input  logic           clk_i,
  input  logic           arst_n_i,
  obi_bus_if.subordinate bus_i
);

  localparam int ROW_W  = $clog2(BANK_WORDS);
  localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  bus_addr_u         addr;
  logic [13:0]       word_idx;
  logic [BANK_W-1:0] bank_sel;
  logic [ROW_W-1:0]  row;
  logic              in_range;
  logic              access;
  logic              wr_en;
  logic [DATA_W-1:0] bank_rdata [NUM_BANKS];
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;

  assign addr     = bus_i.addr;
  assign word_idx = addr.ram.offset[15:2];
  assign bank_sel = BANK_W'(word_idx / BANK_WORDS);
  assign row      = ROW_W'(word_idx % BANK_WORDS);
  assign in_range = (int'(word_idx) < NUM_BANKS * BANK_WORDS);
  assign access   = bus_i.req & bus_i.gnt;
  assign wr_en    = access & bus_i.we & in_range;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    logic [DATA_W-1:0] mem_q [BANK_WORDS];

    always_ff @(posedge clk_i) begin
      if (wr_en && bank_sel == BANK_W'(b)) begin
        for (int i = 0; i < DATA_W / 8; i++) begin
          if (bus_i.be[i]) begin
            mem_q[row][8*i +: 8] <= bus_i.wdata[8*i +: 8];
          end
        end
      end
    end

    assign bank_rdata[b] = mem_q[row];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= access;
    end
  end

  // Beyond capacity reads zero
  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= (in_range && !bus_i.we) ? bank_rdata[bank_sel] : '0;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;

endmodule

/* source/system_bus.sv */
//********************************************************************
// System bus with region decode and response steering
//********************************************************************

`timescale 1ns/100ps

module system_bus
  import core_v_mini_mcu_pkg::*;
(
  input  logic                clk_i,
  input  logic                arst_n_i,

  input  logic                bus_req_i,
  output logic                bus_gnt_o,
  input  logic [ADDR_W-1:0]   bus_addr_i,
  input  logic                bus_we_i,
  input  logic [DATA_W/8-1:0] bus_be_i,
  input  logic [DATA_W-1:0]   bus_wdata_i,
  output logic                bus_rvalid_o,
  output logic [DATA_W-1:0]   bus_rdata_o,

  obi_bus_if.manager          ram_o,
  obi_bus_if.manager          ao_o
);

  bus_addr_u addr;
  logic      hit_ram;
  logic      hit_ao;
  logic      resp_ram_q;
  logic      resp_ao_q;
  logic      resp_none_q;

  assign addr    = bus_addr_i;
  assign hit_ram = (addr.ram.region == RAM_REGION);
  assign hit_ao  = (addr.periph.region == AO_PERIPH_REGION);

  // Always ready
  assign bus_gnt_o = bus_req_i;

  assign ram_o.req   = bus_req_i & hit_ram;
  assign ram_o.gnt   = bus_req_i & hit_ram;
  assign ram_o.addr  = bus_addr_i;
  assign ram_o.we    = bus_we_i;
  assign ram_o.be    = bus_be_i;
  assign ram_o.wdata = bus_wdata_i;

  assign ao_o.req   = bus_req_i & hit_ao;
  assign ao_o.gnt   = bus_req_i & hit_ao;
  assign ao_o.addr  = bus_addr_i;
  assign ao_o.we    = bus_we_i;
  assign ao_o.be    = bus_be_i;
  assign ao_o.wdata = bus_wdata_i;

  // Target of the request in flight
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_ram_q  <= 1'b0;
      resp_ao_q   <= 1'b0;
      resp_none_q <= 1'b0;
    end else begin
      resp_ram_q  <= bus_req_i & hit_ram;
      resp_ao_q   <= bus_req_i & hit_ao;
      resp_none_q <= bus_req_i & ~hit_ram & ~hit_ao;
    end
  end

  // Unmapped regions answer here with zero data
  assign bus_rvalid_o = (resp_ram_q & ram_o.rvalid) | (resp_ao_q & ao_o.rvalid) | resp_none_q;

  always_comb begin
    if (resp_ram_q) begin
      bus_rdata_o = ram_o.rdata;
    end else if (resp_ao_q) begin
      bus_rdata_o = ao_o.rdata;
    end else begin
      bus_rdata_o = '0;
    end
  end

endmodule

/* source/core_v_mini_mcu.sv */
//********************************************************************
// MCU top level with bus, SRAM and always-on peripherals
// Interrupt vector assembly
//********************************************************************

`timescale 1ns/100ps

module core_v_mini_mcu
  import core_v_mini_mcu_pkg::*;
#(
  parameter int NUM_BANKS  = core_v_mini_mcu_pkg::NUM_BANKS,
  parameter int BANK_WORDS = core_v_mini_mcu_pkg::BANK_WORDS
) (
  input  logic                clk_i,
  input  logic                arst_n_i,

  input  logic                bus_req_i,
  output logic                bus_gnt_o,
  input  logic [ADDR_W-1:0]   bus_addr_i,
  input  logic                bus_we_i,
  input  logic [DATA_W/8-1:0] bus_be_i,
  input  logic [DATA_W-1:0]   bus_wdata_i,
  output logic                bus_rvalid_o,
  output logic [DATA_W-1:0]   bus_rdata_o,

  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_oe_o,

  input  logic                intr_ext_i,
  output logic                exit_valid_o,
  output logic [31:0]         exit_value_o,
  output logic [31:0]         irq_o
);

  logic                irq_software;
  logic                irq_timer;
  logic [NUM_GPIO-1:0] irq_gpio;

  obi_bus_if ram_bus ();
  obi_bus_if ao_bus ();

  system_bus system_bus_i (
    .clk_i,
    .arst_n_i,
    .bus_req_i,
    .bus_gnt_o,
    .bus_addr_i,
    .bus_we_i,
    .bus_be_i,
    .bus_wdata_i,
    .bus_rvalid_o,
    .bus_rdata_o,
    .ram_o(ram_bus.manager),
    .ao_o (ao_bus.manager)
  );

  memory_subsystem #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) memory_subsystem_i (
    .clk_i,
    .arst_n_i,
    .bus_i(ram_bus.subordinate)
  );

  ao_peripheral_subsystem ao_peripheral_subsystem_i (
    .clk_i,
    .arst_n_i,
    .bus_i(ao_bus.subordinate),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .exit_valid_o,
    .exit_value_o,
    .irq_software_o(irq_software),
    .irq_timer_o   (irq_timer),
    .irq_gpio_o    (irq_gpio)
  );

  // Unused vector bits stay zero
  always_comb begin
    irq_o                              = '0;
    irq_o[IRQ_SOFTWARE]                = irq_software;
    irq_o[IRQ_TIMER]                   = irq_timer;
    irq_o[IRQ_EXTERNAL]                = intr_ext_i;
    irq_o[IRQ_GPIO_BASE +: NUM_GPIO]   = irq_gpio;
  end

endmodule

/* tb/tb_clk_gen.sv */
//**********************************************************************
// Clock and reset generator for the testbench
//**********************************************************************

`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

/* tb/core_v_mini_mcu_sva.sv */
//**********************************************************************
// Bus protocol assertions, bound to the system bus
//**********************************************************************

`timescale 1ns/100ps

module core_v_mini_mcu_sva (
  input logic clk_i,
  input logic arst_n_i,
  input logic req_i,
  input logic gnt_i,
  input logic rvalid_i
);

  // Grant is immediate
  a_gnt_follows_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    gnt_i == req_i)
    else $error("bus grant differs from bus request");

  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_i && gnt_i) |=> rvalid_i)
    else $error("granted request got no rvalid one cycle later");

  a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_i |-> $past(req_i && gnt_i))
    else $error("rvalid without a grant in the previous cycle");

endmodule

bind system_bus core_v_mini_mcu_sva bus_sva (
  .clk_i,
  .arst_n_i,
  .req_i   (bus_req_i),
  .gnt_i   (bus_gnt_o),
  .rvalid_i(bus_rvalid_o)
);

/* tb/tb_core_v_mini_mcu.sv */
//**********************************************************************
// MCU testbench: stimulus table, reference model, checks,
// watchdog and summary
//**********************************************************************

`timescale 1ns/100ps

module tb_core_v_mini_mcu
  import core_v_mini_mcu_pkg::*;
();

  localparam int RESET_CYCLES = 10;
  localparam int RAM_WORDS    = NUM_BANKS * BANK_WORDS;
  localparam int CHK_NONE     = 0;
  localparam int CHK_EQ       = 1;
  localparam int CHK_MIN      = 2;

  typedef struct {
    string               name;
    logic                we;
    logic [31:0]         addr;
    logic [3:0]          be;
    logic [31:0]         wdata;
    logic [NUM_GPIO-1:0] gpio;
    logic                ext;
    int                  mode;
    logic [31:0]         rdata;
    logic [31:0]         irq;
    int                  settle;
    bit                  b2b;
  } test_row_t;

  logic                clk_i;
  logic                arst_n_i;
  logic                bus_req_i;
  logic                bus_gnt_o;
  logic [31:0]         bus_addr_i;
  logic                bus_we_i;
  logic [3:0]          bus_be_i;
  logic [31:0]         bus_wdata_i;
  logic                bus_rvalid_o;
  logic [31:0]         bus_rdata_o;
  logic [NUM_GPIO-1:0] gpio_i;
  logic [NUM_GPIO-1:0] gpio_o;
  logic [NUM_GPIO-1:0] gpio_oe_o;
  logic                intr_ext_i;
  logic                exit_valid_o;
  logic [31:0]         exit_value_o;
  logic [31:0]         irq_o;

  test_row_t           rows[$];
  logic [31:0]         shadow [RAM_WORDS];
  integer              seed;
  int                  err_count;
  int                  pass_count;
  int                  fail_count;
  bit                  table_ready;
  logic [NUM_GPIO-1:0] cur_gpio;
  logic                cur_ext;
  logic [31:0]         cur_irq;
  logic [31:0]         exp_exit_value;
  logic                exp_exit_valid;
  logic [NUM_GPIO-1:0] exp_gpio_o;
  logic [NUM_GPIO-1:0] exp_gpio_oe;

  tb_clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(RESET_CYCLES)) clk_gen (
    .clk_o   (clk_i),
    .arst_n_o(arst_n_i)
  );

  core_v_mini_mcu #(.NUM_BANKS(NUM_BANKS), .BANK_WORDS(BANK_WORDS)) DUT (.*);

  function automatic logic [31:0] periph_addr(logic [1:0] blk, logic [1:0] idx);
    return {AO_PERIPH_REGION, 10'd0, blk, idx, 2'd0};
  endfunction

  // Word index into the shadow or -1 outside the SRAM
  function automatic int ram_word(logic [31:0] addr);
    if (addr[31:16] != RAM_REGION || 32'(addr[15:2]) >= RAM_WORDS) begin
      return -1;
    end
    return 32'(addr[15:2]);
  endfunction

  function automatic void ram_store(logic [31:0] addr, logic [3:0] be, logic [31:0] data);
    int w;
    w = ram_word(addr);
    for (int b = 0; b < 4; b++) begin
      if (w >= 0 && be[b]) begin
        shadow[w][8*b +: 8] = data[8*b +: 8];
      end
    end
  endfunction

  function automatic logic [31:0] ram_load(logic [31:0] addr);
    int w;
    w = ram_word(addr);
    return (w >= 0) ? shadow[w] : 32'd0;
  endfunction

  function automatic void add_write(string name, logic [31:0] addr, logic [3:0] be,
                                    logic [31:0] data, int settle, bit b2b);
    test_row_t r;
    r = '{name, 1'b1, addr, be, data, cur_gpio, cur_ext, CHK_NONE, 32'd0, cur_irq,
          settle, b2b};
    ram_store(addr, be, data);
    rows.push_back(r);
  endfunction

  function automatic void add_read(string name, logic [31:0] addr, int mode,
                                   logic [31:0] exp, int settle, bit b2b);
    test_row_t r;
    r = '{name, 1'b0, addr, 4'hF, 32'd0, cur_gpio, cur_ext, mode, exp, cur_irq, settle, b2b};
    rows.push_back(r);
  endfunction

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act,
                             bit at_least = 1'b0);
    bit ok;
    ok = at_least ? (act >= exp) : (act === exp);
    if (!ok) begin
      err_count++;
      $display("Fail %s: expected %s%h, actual %h", name, at_least ? ">= " : "", exp, act);
    end
  endtask

  task automatic check_outputs(string name, logic [31:0] exp_irq);
    check_value({name, " irq_o"}, exp_irq, irq_o);
    check_value({name, " exit_value_o"}, exp_exit_value, exit_value_o);
    check_value({name, " exit_valid_o"}, 32'(exp_exit_valid), 32'(exit_valid_o));
    check_value({name, " gpio_o"}, 32'(exp_gpio_o), 32'(gpio_o));
    check_value({name, " gpio_oe_o"}, 32'(exp_gpio_oe), 32'(gpio_oe_o));
  endtask

  task automatic finish_test(string name, int errs_before);
    if (err_count == errs_before) begin
      pass_count++;
      $display("Test %s: passed", name);
    end else begin
      fail_count++;
      $display("Test %s: failed", name);
    end
  endtask

  // Output registers as the register map defines them
  function automatic void track_write(test_row_t r);
    if (!r.we || r.addr[31:16] != AO_PERIPH_REGION) begin
      return;
    end
    case ({r.addr[5:4], r.addr[3:2]})
      {AO_BLOCK, EXIT_VALUE_REG}: exp_exit_value = r.wdata;
      {AO_BLOCK, EXIT_VALID_REG}: exp_exit_valid = r.wdata[0];
      {GPIO_BLOCK, GPIO_OUT_REG}: exp_gpio_o = r.wdata[NUM_GPIO-1:0];
      {GPIO_BLOCK, GPIO_OE_REG}:  exp_gpio_oe = r.wdata[NUM_GPIO-1:0];
      default: ;
    endcase
  endfunction

  task automatic drive_row(test_row_t r);
    bus_req_i   = 1'b1;
    bus_we_i    = r.we;
    bus_addr_i  = r.addr;
    bus_be_i    = r.be;
    bus_wdata_i = r.wdata;
    gpio_i      = r.gpio;
    intr_ext_i  = r.ext;
  endtask

  task automatic idle_bus();
    bus_req_i = 1'b0;
    bus_we_i  = 1'b0;
  endtask

  task automatic build_table();
    logic [31:0] addrs [6];
    logic [3:0]  be_pat [6];
    logic [31:0] data;
    addrs  = '{32'h0000, 32'h0004, 32'h03FC, 32'h0400, 32'h0404, 32'h07FC};
    be_pat = '{4'b0001, 4'b0110, 4'b1000, 4'b0101, 4'b1100, 4'b0010};
    cur_gpio = '0;
    cur_ext  = 1'b1;
    cur_irq  = '0;
    cur_irq[IRQ_EXTERNAL] = 1'b1;
    add_read("ext_irq_high", periph_addr(AO_BLOCK, EXIT_VALID_REG), CHK_EQ, 0, 0, 0);
    cur_ext = 1'b0;
    cur_irq[IRQ_EXTERNAL] = 1'b0;
    add_read("ext_irq_low", periph_addr(AO_BLOCK, MSIP_REG), CHK_EQ, 0, 0, 0);
    // Full words in both banks first so no byte stays unknown
    for (int i = 0; i < 6; i++) begin
      data = $random(seed);
      add_write($sformatf("ram_wr_full_%0d", i), addrs[i], 4'hF, data, 0, 1);
    end
    for (int i = 0; i < 6; i++) begin
      data = $random(seed);
      add_write($sformatf("ram_wr_part_%0d", i), addrs[i], be_pat[i], data, 0, 1);
    end
    for (int i = 0; i < 6; i++) begin
      add_read($sformatf("ram_rd_%0d", i), addrs[i], CHK_EQ, ram_load(addrs[i]), 0, 1);
    end
    data = $random(seed);
    add_write("ram_wr_then_rd", 32'h0008, 4'hF, data, 0, 1);
    add_read("ram_rd_after_wr", 32'h0008, CHK_EQ, ram_load(32'h0008), 0, 0);
    add_write("unmapped_wr", 32'h1000_0000, 4'hF, 32'hDEAD_BEEF, 0, 1);
    add_read("unmapped_rd", 32'h1000_0000, CHK_EQ, 0, 0, 1);
    add_write("beyond_wr", 32'h0000_0800, 4'hF, 32'h5A5A_A5A5, 0, 1);
    add_read("beyond_rd", 32'h0000_0800, CHK_EQ, 0, 0, 1);
    add_read("beyond_rd_top", 32'h0000_FFFC, CHK_EQ, 0, 0, 1);
    add_read("ram_after_stray", 32'h0000, CHK_EQ, ram_load(32'h0000), 0, 0);
    // Peripheral writes are full word whatever the byte enables
    add_write("exit_value_wr", periph_addr(AO_BLOCK, EXIT_VALUE_REG), 4'h1, 32'hC0DE_0042, 0, 0);
    add_write("exit_valid_wr", periph_addr(AO_BLOCK, EXIT_VALID_REG), 4'hF, 1, 0, 0);
    add_read("exit_value_rd", periph_addr(AO_BLOCK, EXIT_VALUE_REG), CHK_EQ, 32'hC0DE_0042, 0, 0);
    add_write("block3_wr", periph_addr(2'd3, 2'd0), 4'hF, 32'h1234_5678, 0, 1);
    add_read("block3_rd", periph_addr(2'd3, 2'd0), CHK_EQ, 0, 0, 1);
    add_read("exit_after_block3", periph_addr(AO_BLOCK, EXIT_VALUE_REG), CHK_EQ,
             32'hC0DE_0042, 0, 0);
    cur_irq[IRQ_SOFTWARE] = 1'b1;
    add_write("msip_set", periph_addr(AO_BLOCK, MSIP_REG), 4'hF, 1, 0, 0);
    add_read("msip_rd", periph_addr(AO_BLOCK, MSIP_REG), CHK_EQ, 1, 0, 0);
    cur_irq[IRQ_SOFTWARE] = 1'b0;
    add_write("msip_clr", periph_addr(AO_BLOCK, MSIP_REG), 4'hF, 0, 0, 0);
    add_write("gpio_out_wr", periph_addr(GPIO_BLOCK, GPIO_OUT_REG), 4'hF, 32'hA5, 0, 1);
    add_write("gpio_oe_wr", periph_addr(GPIO_BLOCK, GPIO_OE_REG), 4'hF, 32'h0F, 0, 1);
    add_read("gpio_out_rd", periph_addr(GPIO_BLOCK, GPIO_OUT_REG), CHK_EQ, 32'hA5, 0, 0);
    // Edge must show on irq_o within five cycles of the pin change
    cur_gpio = 8'h04;
    cur_irq[IRQ_GPIO_BASE + 2] = 1'b1;
    add_read("gpio_rise_pin2", periph_addr(GPIO_BLOCK, GPIO_OE_REG), CHK_EQ, 32'h0F, 4, 0);
    add_read("gpio_in_rd", periph_addr(GPIO_BLOCK, GPIO_IN_REG), CHK_EQ, 32'h04, 0, 0);
    add_read("gpio_intr_rd", periph_addr(GPIO_BLOCK, GPIO_INTR_REG), CHK_EQ, 32'h04, 0, 0);
    cur_irq[IRQ_GPIO_BASE + 2] = 1'b0;
    add_write("gpio_intr_clr2", periph_addr(GPIO_BLOCK, GPIO_INTR_REG), 4'hF, 32'h04, 0, 0);
    cur_gpio = 8'h84;
    cur_irq[IRQ_GPIO_BASE + 7] = 1'b1;
    add_read("gpio_rise_pin7", periph_addr(GPIO_BLOCK, GPIO_OUT_REG), CHK_EQ, 32'hA5, 4, 0);
    cur_irq[IRQ_GPIO_BASE + 7] = 1'b0;
    add_write("gpio_intr_clr7", periph_addr(GPIO_BLOCK, GPIO_INTR_REG), 4'hF, 32'h80, 0, 0);
    add_read("gpio_intr_rd_clr", periph_addr(GPIO_BLOCK, GPIO_INTR_REG), CHK_EQ, 0, 0, 0);
    add_write("timer_cmp_wr", periph_addr(TIMER_BLOCK, TIMER_CMP_REG), 4'hF, 20, 0, 0);
    cur_irq[IRQ_TIMER] = 1'b1;
    add_write("timer_enable", periph_addr(TIMER_BLOCK, TIMER_CTRL_REG), 4'hF, 1, 40, 0);
    // A zero count below the compare value of 20 drops the interrupt
    cur_irq[IRQ_TIMER] = 1'b0;
    add_write("timer_count_zero", periph_addr(TIMER_BLOCK, TIMER_COUNT_REG), 4'hF, 0, 0, 1);
    add_write("timer_cmp_high", periph_addr(TIMER_BLOCK, TIMER_CMP_REG), 4'hF, 1000, 0, 0);
    add_write("timer_count_wr", periph_addr(TIMER_BLOCK, TIMER_COUNT_REG), 4'hF, 5, 0, 1);
    add_read("timer_count_rd", periph_addr(TIMER_BLOCK, TIMER_COUNT_REG), CHK_MIN, 5, 0, 1);
    add_read("timer_cmp_rd", periph_addr(TIMER_BLOCK, TIMER_CMP_REG), CHK_EQ, 1000, 0, 0);
    add_write("timer_disable", periph_addr(TIMER_BLOCK, TIMER_CTRL_REG), 4'hF, 0, 0, 1);
    add_read("timer_ctrl_rd", periph_addr(TIMER_BLOCK, TIMER_CTRL_REG), CHK_EQ, 0, 0, 0);
  endtask

  task automatic run_table();
    test_row_t r;
    int        errs_before;
    drive_row(rows[0]);
    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      errs_before = err_count;
      // Response of the request granted at the last rising edge
      @(negedge clk_i);
      check_value({r.name, " gnt"}, 32'd1, 32'(bus_gnt_o));
      check_value({r.name, " rvalid"}, 32'd1, 32'(bus_rvalid_o));
      if (r.mode != CHK_NONE) begin
        check_value({r.name, " rdata"}, r.rdata, bus_rdata_o, r.mode == CHK_MIN);
      end
      track_write(r);
      if (r.settle > 0) begin
        idle_bus();
        for (int c = 0; c < r.settle && irq_o !== r.irq; c++) begin
          @(negedge clk_i);
        end
      end
      check_outputs(r.name, r.irq);
      finish_test(r.name, errs_before);
      if (i + 1 < rows.size()) begin
        if (!r.b2b) begin
          idle_bus();
          @(negedge clk_i);
        end
        drive_row(rows[i + 1]);
      end
    end
    idle_bus();
  endtask

  initial begin
    int errs_before;
    seed           = 73329;
    err_count      = 0;
    pass_count     = 0;
    fail_count     = 0;
    table_ready    = 1'b0;
    exp_exit_value = '0;
    exp_exit_valid = 1'b0;
    exp_gpio_o     = '0;
    exp_gpio_oe    = '0;
    bus_req_i      = 1'b0;
    bus_addr_i     = '0;
    bus_we_i       = 1'b0;
    bus_be_i       = '0;
    bus_wdata_i    = '0;
    gpio_i         = '0;
    intr_ext_i     = 1'b0;
    build_table();
    table_ready = 1'b1;
    wait (arst_n_i === 1'b1);
    @(negedge clk_i);
    errs_before = err_count;
    check_value("reset_outputs rvalid", 32'd0, 32'(bus_rvalid_o));
    check_outputs("reset_outputs", 32'd0);
    finish_test("reset_outputs", errs_before);
    run_table();
    $display("Summary: %0d tests passed, %0d tests failed, %0d mismatches",
             pass_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Budget of 20 cycles per row plus the reset
  initial begin
    wait (table_ready);
    repeat (rows.size() * 20 + RESET_CYCLES) @(posedge clk_i);
    $display("Watchdog timeout: the tests did not finish in the expected time");
    $display("Test failures found");
    $finish;
  end

endmodule

/* core_v_mini_mcu.f */
source/core_v_mini_mcu_pkg.sv
source/obi_bus_if.sv
source/rv_timer.sv
source/gpio.sv
source/ao_peripheral_subsystem.sv
source/memory_subsystem.sv
source/system_bus.sv
source/core_v_mini_mcu.sv
tb/tb_clk_gen.sv
tb/core_v_mini_mcu_sva.sv
tb/tb_core_v_mini_mcu.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then search the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f core_v_mini_mcu.f \
  --top-module tb_core_v_mini_mcu -o tb_sim > build.log 2>&1 &&
  ./obj_dir/tb_sim > sim.log 2>&1 ||
  echo "Build or simulation ended abnormally"
grep -q 'All tests passed!' sim.log && echo "PASS" && exit 0 ||
  { echo "FAIL"; exit 1; }
